// File: all.f
+incdir+.
icache_pkg.sv
icache_ctrl_fsm.sv
linefill_beat_counter.sv
linefill_buffer.sv
icache_tag_array.sv
icache_data_array.sv
icache_top.sv
tb_clock_gen.sv
biu_mem_model.sv
icache_tb.sv

// File: Bender.yml
package:
  name: icache

export_include_dirs:
  - .

sources:
  - files:
      - icache_pkg.sv
      - icache_ctrl_fsm.sv
      - linefill_beat_counter.sv
      - linefill_buffer.sv
      - icache_tag_array.sv
      - icache_data_array.sv
      - icache_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - biu_mem_model.sv
      - icache_tb.sv

// File: icache_tb.sv
`timescale 1ns/1ns

`include "icache_settings.svh"

module icache_tb import icache_pkg::*; ();

   localparam int NUM_DIRECTED = 21;
   localparam int NUM_RANDOM   = 60;
   localparam int NUM_LOOKUPS  = NUM_DIRECTED + NUM_RANDOM;
   localparam int RESET_CYCLES = 16;
   // sample point after the falling edge
   localparam int SETTLE_NS    = 5;

   logic        clk;
   logic        rst_n;
   logic        req;
   fetch_addr_u addr;
   logic        ack;
   logic        cancel;
   logic        data_valid;
   fetch_word_t data;
   logic        biu_req;
   logic [28:0] biu_addr;
   logic        biu_ack;
   logic        biu_data_valid;
   logic        biu_data_last;
   fetch_word_t biu_data;

   integer seed;
   int     err_count;
   int     test_err_start;
   int     tests_run;
   int     tests_failed;
   string  cur_test;

   // reference tags and valid bits per set
   logic [1:0] m_valid [0:`ICACHE_SETS-1];
   line_tag_t  m_tag   [0:`ICACHE_SETS-1][0:1];

   // small pools so that sets fill up and evict
   line_tag_t                                    tag_pool   [0:2];
   logic [`ICACHE_INDEX_MSB-`ICACHE_INDEX_LSB:0] index_pool [0:3];

   tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(RESET_CYCLES)) u_clk (
      .clk   (clk),
      .rst_n (rst_n)
   );

   icache_top DUT (
      .clk            (clk),
      .rst_n          (rst_n),
      .req            (req),
      .addr           (addr),
      .ack            (ack),
      .cancel         (cancel),
      .data_valid     (data_valid),
      .data           (data),
      .biu_req        (biu_req),
      .biu_addr       (biu_addr),
      .biu_ack        (biu_ack),
      .biu_data_valid (biu_data_valid),
      .biu_data_last  (biu_data_last),
      .biu_data       (biu_data)
   );

   biu_mem_model #(.SEED(8902)) u_biu (
      .clk            (clk),
      .rst_n          (rst_n),
      .biu_req        (biu_req),
      .biu_addr       (biu_addr),
      .biu_ack        (biu_ack),
      .biu_data_valid (biu_data_valid),
      .biu_data_last  (biu_data_last),
      .biu_data       (biu_data)
   );

   function automatic fetch_word_t expected_word(input logic [28:0] a);
      return {6'b0, a, ~a};
   endfunction

   function automatic logic model_hit(input fetch_addr_u a);
      logic h0;
      logic h1;
      h0 = m_valid[a.f.index][0] && (m_tag[a.f.index][0] == a.f.tag);
      h1 = m_valid[a.f.index][1] && (m_tag[a.f.index][1] == a.f.tag);
      return h0 || h1;
   endfunction

   task automatic model_fill(input fetch_addr_u a);
      int v;
      // way1 only if way0 holds a line and way1 is free
      v = (m_valid[a.f.index][0] && !m_valid[a.f.index][1]) ? 1 : 0;
      m_valid[a.f.index][v] = 1'b1;
      m_tag[a.f.index][v]   = a.f.tag;
   endtask

   task automatic check_word(input string what, input fetch_word_t exp, input fetch_word_t act);
      if (exp !== act) begin
         $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
         err_count++;
      end
   endtask

   task automatic check_addr(input string what, input logic [28:0] exp, input logic [28:0] act);
      if (exp !== act) begin
         $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
         err_count++;
      end
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      if (exp !== act) begin
         $display("[ERROR] %s %s: expected %b, actual %b", cur_test, what, exp, act);
         err_count++;
      end
   endtask

   task automatic start_test(input string name);
      cur_test       = name;
      test_err_start = err_count;
      tests_run++;
   endtask

   task automatic end_test();
      int errs;
      errs = err_count - test_err_start;
      if (errs == 0) begin
         $display("test %-10s ok", cur_test);
      end else begin
         $display("test %-10s FAILED with %0d errors", cur_test, errs);
         tests_failed++;
      end
   endtask

   // cancel_mode 0 none, 1 with the request, 2 during the fill
   task automatic run_lookup(input logic [28:0] a, input int cancel_mode);
      fetch_addr_u fa;
      logic        exp_hit;
      logic        exp_valid;
      int          mode;
      logic        grant_seen;
      logic        pulsed;
      logic        last_seen;
      fa.raw     = a;
      exp_hit    = model_hit(fa);
      mode       = (exp_hit && cancel_mode == 2) ? 0 : cancel_mode;
      exp_valid  = (mode == 0);
      grant_seen = 1'b0;
      pulsed     = 1'b0;
      last_seen  = 1'b0;
      @(negedge clk);
      req    = 1'b1;
      addr   = fa;
      cancel = (mode == 1);
      #SETTLE_NS;
      check_bit("ack on req", 1'b1, ack);
      while (!ack) begin
         @(negedge clk);
         #SETTLE_NS;
      end
      // accepted on the coming edge, next cycle is ic2
      @(negedge clk);
      cancel = 1'b0;
      #SETTLE_NS;
      check_bit("ack after accept", 1'b0, ack);
      if (exp_hit) begin
         check_bit("biu_req on hit", 1'b0, biu_req);
         check_bit("data_valid on hit", exp_valid, data_valid);
         if (exp_valid && data_valid) begin
            check_word("hit data", expected_word(a), data);
         end
      end else begin
         check_addr("biu_addr", {a[28:2], 2'b00}, biu_addr);
         while (!last_seen) begin
            check_bit("ack during miss", 1'b0, ack);
            if (grant_seen) begin
               check_bit("biu_req during fill", 1'b0, biu_req);
            end else begin
               check_bit("biu_req held", 1'b1, biu_req);
            end
            if (biu_ack) begin
               grant_seen = 1'b1;
            end
            if (biu_data_valid && biu_data_last) begin
               last_seen = 1'b1;
            end else begin
               check_bit("data_valid before last beat", 1'b0, data_valid);
               @(negedge clk);
               // one cycle of cancel once the burst is granted
               cancel = (mode == 2) && grant_seen && !pulsed;
               if (cancel) begin
                  pulsed = 1'b1;
               end
               #SETTLE_NS;
            end
         end
         check_bit("data_valid on last beat", exp_valid, data_valid);
         if (exp_valid && data_valid) begin
            check_word("fill data", expected_word(a), data);
         end
         model_fill(fa);
      end
   endtask

   task automatic pick_random_addr(output logic [28:0] a);
      int r;
      r = {$random(seed)} % 8;
      if (r == 0) begin
         a = 29'($random(seed));
      end else begin
         a = {tag_pool[{$random(seed)} % 3], index_pool[{$random(seed)} % 4],
              2'({$random(seed)} % 4)};
      end
   endtask

   initial begin
      repeat (RESET_CYCLES + NUM_LOOKUPS * 200) @(posedge clk);
      $display("timeout: lookups not finished within %0d cycles", NUM_LOOKUPS * 200);
      $display("Some tests failed");
      $finish;
   end

   initial begin
      int          i;
      int          r;
      int          mode;
      logic [28:0] a;
      seed           = 8902;
      req            = 1'b0;
      addr           = '0;
      cancel         = 1'b0;
      err_count      = 0;
      test_err_start = 0;
      tests_run      = 0;
      tests_failed   = 0;
      cur_test       = "reset";
      for (i = 0; i < `ICACHE_SETS; i++) begin
         m_valid[i] = 2'b00;
      end
      tag_pool   = '{17'h000a5, 17'h01b3c, 17'h00777};
      index_pool = '{10'h003, 10'h155, 10'h2aa, 10'h3ff};
      @(posedge rst_n);

      // one cold miss per word offset, beat three included
      start_test("cold_miss");
      #SETTLE_NS;
      check_bit("biu_req after reset", 1'b0, biu_req);
      check_bit("data_valid after reset", 1'b0, data_valid);
      for (i = 0; i < 4; i++) begin
         run_lookup({17'h01234, 10'(16 + i), 2'(i)}, 0);
      end
      end_test();

      start_test("hit");
      for (i = 0; i < 4; i++) begin
         run_lookup({17'h01234, 10'(16 + i), 2'(i)}, 0);
      end
      end_test();

      // third tag pushes out way0, then way0 again
      start_test("evict");
      run_lookup({17'h00101, 10'h020, 2'd1}, 0);
      run_lookup({17'h00202, 10'h020, 2'd2}, 0);
      run_lookup({17'h00101, 10'h020, 2'd3}, 0);
      run_lookup({17'h00202, 10'h020, 2'd0}, 0);
      run_lookup({17'h00303, 10'h020, 2'd1}, 0);
      run_lookup({17'h00202, 10'h020, 2'd2}, 0);
      run_lookup({17'h00101, 10'h020, 2'd3}, 0);
      end_test();

      start_test("cancel");
      run_lookup({17'h01234, 10'd16, 2'd0}, 1);
      run_lookup({17'h01234, 10'd16, 2'd0}, 0);
      run_lookup({17'h00abc, 10'h030, 2'd1}, 1);
      run_lookup({17'h00abc, 10'h030, 2'd1}, 0);
      run_lookup({17'h00abc, 10'h031, 2'd3}, 2);
      run_lookup({17'h00abc, 10'h031, 2'd3}, 0);
      end_test();

      start_test("random");
      for (i = 0; i < NUM_RANDOM; i++) begin
         pick_random_addr(a);
         r    = {$random(seed)} % 8;
         mode = (r == 0) ? 1 : ((r == 1) ? 2 : 0);
         run_lookup(a, mode);
      end
      end_test();

      @(negedge clk);
      req    = 1'b0;
      cancel = 1'b0;
      repeat (2) @(negedge clk);
      $display("tests %0d, passed %0d, failed %0d, errors %0d",
               tests_run, tests_run - tests_failed, tests_failed, err_count);
      if (err_count == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// File: biu_mem_model.sv
`timescale 1ns/1ns

module biu_mem_model import icache_pkg::*; #(
   parameter int SEED = 1
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        biu_req,
   input  logic [28:0] biu_addr,
   output logic        biu_ack,
   output logic        biu_data_valid,
   output logic        biu_data_last,
   output fetch_word_t biu_data
);

   integer      seed;
   int          gap;
   int          i;
   logic [28:0] line_addr;
   logic [28:0] beat_addr;

   initial begin
      seed           = SEED;
      biu_ack        = 1'b0;
      biu_data_valid = 1'b0;
      biu_data_last  = 1'b0;
      biu_data       = '0;
      forever begin
         @(negedge clk);
         if (rst_n && biu_req) begin
            line_addr = biu_addr;
            // grant after 0..3 idle cycles
            gap = {$random(seed)} % 4;
            repeat (gap) @(negedge clk);
            biu_ack = 1'b1;
            @(negedge clk);
            biu_ack = 1'b0;
            // four ascending beats, gaps of 0..2 cycles
            for (i = 0; i < 4; i++) begin
               gap = {$random(seed)} % 3;
               repeat (gap) @(negedge clk);
               beat_addr      = line_addr + 29'(i);
               biu_data_valid = 1'b1;
               biu_data_last  = (i == 3);
               // memory word is the address next to its inverse
               biu_data       = {6'b0, beat_addr, ~beat_addr};
               @(negedge clk);
               biu_data_valid = 1'b0;
               biu_data_last  = 1'b0;
            end
         end
      end
   end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 16
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD_NS / 2) clk = ~clk;
      end
   end

   // release on a falling edge, away from the sampling edge
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

// File: icache_top.sv
`timescale 1ns/1ns

module icache_top import icache_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        req,
   input  fetch_addr_u addr,
   output logic        ack,
   input  logic        cancel,
   output logic        data_valid,
   output fetch_word_t data,
   output logic        biu_req,
   output logic [28:0] biu_addr,
   input  logic        biu_ack,
   input  logic        biu_data_valid,
   input  logic        biu_data_last,
   input  fetch_word_t biu_data
);

   logic        lookup_en;
   fetch_addr_u lookup_addr;
   logic        hit;
   way_t        hit_way;
   way_t        fill_way;
   logic        fill_busy;
   beat_t       beat;
   logic        cnt_last;
   fetch_word_t rd_data;
   fetch_word_t fwd_data;

   icache_ctrl_fsm u_ctrl (
      .clk         (clk),
      .rst_n       (rst_n),
      .req         (req),
      .addr        (addr),
      .ack         (ack),
      .cancel      (cancel),
      .data_valid  (data_valid),
      .lookup_en   (lookup_en),
      .lookup_addr (lookup_addr),
      .hit         (hit),
      .biu_req     (biu_req),
      .biu_addr    (biu_addr),
      .biu_ack     (biu_ack),
      .beat_valid  (biu_data_valid),
      .beat_last   (biu_data_last),
      .fill_busy   (fill_busy)
   );

   // restarts on every burst grant
   linefill_beat_counter u_cnt (
      .clk        (clk),
      .rst_n      (rst_n),
      .start      (biu_ack),
      .beat_valid (biu_data_valid),
      .beat       (beat),
      .beat_last  (cnt_last)
   );

   linefill_buffer u_lfb (
      .clk        (clk),
      .beat_valid (biu_data_valid),
      .beat       (beat),
      .beat_data  (biu_data),
      .word       (lookup_addr.f.word),
      .fwd_data   (fwd_data)
   );

   // victim latched at grant, tag written on the counted last beat
   icache_tag_array u_tag (
      .clk         (clk),
      .rst_n       (rst_n),
      .lookup_en   (lookup_en),
      .lookup_addr (lookup_addr),
      .read_index  (addr.f.index),
      .hit         (hit),
      .hit_way     (hit_way),
      .fill_start  (biu_ack),
      .fill_done   (cnt_last),
      .fill_way    (fill_way)
   );

   icache_data_array u_data (
      .clk        (clk),
      .read_en    (lookup_en),
      .read_index (addr.f.index),
      .read_word  (addr.f.word),
      .hit_way    (hit_way),
      .rd_data    (rd_data),
      .wr_en      (biu_data_valid & fill_busy),
      .wr_way     (fill_way),
      .wr_index   (lookup_addr.f.index),
      .wr_beat    (beat),
      .wr_data    (biu_data)
   );

   // fill state means linefill delivery, otherwise array hit data
   assign data = fill_busy ? fwd_data : rd_data;

   // local beat count agrees with the biu last flag
   a_last_beat_match: assert property (@(posedge clk) disable iff (!rst_n)
      biu_data_valid |-> (cnt_last == biu_data_last));

endmodule

// File: icache_data_array.sv
`timescale 1ns/1ns

`include "icache_settings.svh"

module icache_data_array import icache_pkg::*; (
   input  logic        clk,
   input  logic        read_en,
   input  logic [`ICACHE_INDEX_MSB-`ICACHE_INDEX_LSB:0] read_index,
   input  beat_t       read_word,
   input  way_t        hit_way,
   output fetch_word_t rd_data,
   input  logic        wr_en,
   input  way_t        wr_way,
   input  logic [`ICACHE_INDEX_MSB-`ICACHE_INDEX_LSB:0] wr_index,
   input  beat_t       wr_beat,
   input  fetch_word_t wr_data
);

   // one word per set and beat
   fetch_word_t way0_mem [0:`ICACHE_SETS*`ICACHE_LINE_BEATS-1];
   fetch_word_t way1_mem [0:`ICACHE_SETS*`ICACHE_LINE_BEATS-1];

   fetch_word_t rd0;
   fetch_word_t rd1;

   // both ways read at ic1, hit way picked in ic2
   always_ff @(posedge clk) begin
      if (read_en) begin
         rd0 <= way0_mem[{read_index, read_word}];
         rd1 <= way1_mem[{read_index, read_word}];
      end
   end

   assign rd_data = hit_way ? rd1 : rd0;

   // fill beats into the allocated way
   always_ff @(posedge clk) begin
      if (wr_en && !wr_way) begin
         way0_mem[{wr_index, wr_beat}] <= wr_data;
      end
      if (wr_en && wr_way) begin
         way1_mem[{wr_index, wr_beat}] <= wr_data;
      end
   end

endmodule

// File: icache_tag_array.sv
`timescale 1ns/1ns

`include "icache_settings.svh"

module icache_tag_array import icache_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        lookup_en,
   input  fetch_addr_u lookup_addr,
   input  logic [`ICACHE_INDEX_MSB-`ICACHE_INDEX_LSB:0] read_index,
   output logic        hit,
   output way_t        hit_way,
   input  logic        fill_start,
   input  logic        fill_done,
   output way_t        fill_way
);

   line_tag_t          tag_mem [0:1][0:`ICACHE_SETS-1];
   logic [`ICACHE_SETS-1:0] valid [0:1];

   // ic2 copies of the set
   line_tag_t rd_tag0;
   line_tag_t rd_tag1;
   logic      rd_valid0;
   logic      rd_valid1;
   logic      lu_q;
   logic      match0;
   logic      match1;

   assign match0 = rd_valid0 & (rd_tag0 == lookup_addr.f.tag);
   assign match1 = rd_valid1 & (rd_tag1 == lookup_addr.f.tag);

   // result only for the cycle after acceptance
   assign hit     = lu_q & (match0 | match1);
   assign hit_way = match1;

   // sync read at acceptance
   always_ff @(posedge clk) begin
      if (lookup_en) begin
         rd_tag0   <= tag_mem[0][read_index];
         rd_tag1   <= tag_mem[1][read_index];
         rd_valid0 <= valid[0][read_index];
         rd_valid1 <= valid[1][read_index];
      end
      // tag goes in with the last beat
      if (fill_done) begin
         tag_mem[fill_way][lookup_addr.f.index] <= lookup_addr.f.tag;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         lu_q     <= 1'b0;
         fill_way <= 1'b0;
         valid[0] <= '0;
         valid[1] <= '0;
      end else begin
         lu_q <= lookup_en;
         // way1 only when way0 is taken and way1 is free
         if (fill_start) begin
            fill_way <= rd_valid0 & ~rd_valid1;
         end
         if (fill_done) begin
            valid[fill_way][lookup_addr.f.index] <= 1'b1;
         end
      end
   end

   // a line is never allocated twice in one set
   a_one_hit_way: assert property (@(posedge clk) disable iff (!rst_n)
      lu_q |-> !(match0 && match1));

endmodule

// File: linefill_buffer.sv
`timescale 1ns/1ns

`include "icache_settings.svh"

module linefill_buffer import icache_pkg::*; (
   input  logic        clk,
   input  logic        beat_valid,
   input  beat_t       beat,
   input  fetch_word_t beat_data,
   input  beat_t       word,
   output fetch_word_t fwd_data
);

   localparam beat_t LAST_BEAT = beat_t'(`ICACHE_LINE_BEATS - 1);

   // beats before the last one
   fetch_word_t lfb [0:`ICACHE_LINE_BEATS-2];

   always_ff @(posedge clk) begin
      if (beat_valid && (beat != LAST_BEAT)) begin
         lfb[beat] <= beat_data;
      end
   end

   // critical word select
   always_comb begin
      case (word)
         2'd0: begin
            fwd_data = lfb[0];
         end
         2'd1: begin
            fwd_data = lfb[1];
         end
         2'd2: begin
            fwd_data = lfb[2];
         end
         default: begin
            // last beat is not stored yet, take it straight off the bus
            fwd_data = beat_data;
         end
      endcase
   end

endmodule

// File: linefill_beat_counter.sv
`timescale 1ns/1ns

`include "icache_settings.svh"

module linefill_beat_counter import icache_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  start,
   input  logic  beat_valid,
   output beat_t beat,
   output logic  beat_last
);

   beat_t cnt;

   // beat number of the data on the bus right now
   assign beat = cnt;

   // final beat of the line, only while it is on the bus
   assign beat_last = beat_valid & (cnt == beat_t'(`ICACHE_LINE_BEATS - 1));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cnt <= '0;
      end else if (start) begin
         // biu ack opens a new burst
         cnt <= '0;
      end else if (beat_valid) begin
         cnt <= cnt + beat_t'(1);
      end
   end

endmodule

// File: icache_ctrl_fsm.sv
`timescale 1ns/1ns

module icache_ctrl_fsm import icache_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        req,
   input  fetch_addr_u addr,
   output logic        ack,
   input  logic        cancel,
   output logic        data_valid,
   output logic        lookup_en,
   output fetch_addr_u lookup_addr,
   input  logic        hit,
   output logic        biu_req,
   output logic [28:0] biu_addr,
   input  logic        biu_ack,
   input  logic        beat_valid,
   input  logic        beat_last,
   output logic        fill_busy
);

   localparam logic [1:0] IDLE    = 2'd0;
   localparam logic [1:0] LOOKUP  = 2'd1;
   localparam logic [1:0] REQUEST = 2'd2;
   localparam logic [1:0] FILL    = 2'd3;

   logic [1:0] state;
   logic [1:0] state_nxt;
   logic       accept;
   logic       deliver;
   logic       cancel_q;

   // only one lookup in flight, ack only when idle
   assign ack    = req & (state == IDLE);
   assign accept = req & ack;

   // arrays read at acceptance
   assign lookup_en = accept;

   // result is due either on the ic2 hit or on the last fill beat
   assign deliver = ((state == LOOKUP) & hit) |
                    ((state == FILL) & beat_valid & beat_last);

   // cancel level or a pending cancel kills the delivery
   assign data_valid = deliver & ~(cancel | cancel_q);

   // miss raises the request in the lookup cycle itself
   assign biu_req   = ((state == LOOKUP) & ~hit) | (state == REQUEST);
   // line aligned burst address
   assign biu_addr  = {lookup_addr.raw[28:2], 2'b00};
   assign fill_busy = (state == FILL);

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: begin
            if (accept) begin
               state_nxt = LOOKUP;
            end
         end
         LOOKUP: begin
            // biu may ack in the same cycle as the miss
            if (hit) begin
               state_nxt = IDLE;
            end else if (biu_ack) begin
               state_nxt = FILL;
            end else begin
               state_nxt = REQUEST;
            end
         end
         REQUEST: begin
            if (biu_ack) begin
               state_nxt = FILL;
            end
         end
         default: begin
            if (beat_valid & beat_last) begin
               state_nxt = IDLE;
            end
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state    <= IDLE;
         cancel_q <= 1'b0;
      end else begin
         state <= state_nxt;
         // remember a cancel until the next delivery slot
         if (cancel | deliver) begin
            cancel_q <= cancel & ~deliver;
         end
      end
   end

   // ic2 address
   always_ff @(posedge clk) begin
      if (accept) begin
         lookup_addr <= addr;
      end
   end

   // a granted burst turns into a fill with no new request
   a_no_req_in_fill: assert property (@(posedge clk) disable iff (!rst_n)
      (biu_req && biu_ack) |=> (fill_busy && !biu_req));

   // lookup blocks further requests
   a_no_ack_in_lookup: assert property (@(posedge clk) disable iff (!rst_n)
      accept |=> !ack);

endmodule

// File: icache_pkg.sv
`include "icache_settings.svh"

package icache_pkg;

   // one of two ways
   typedef logic way_t;

   // beat number inside a line
   typedef logic [$clog2(`ICACHE_LINE_BEATS)-1:0] beat_t;

   typedef logic [63:0] fetch_word_t;

   typedef logic [`ICACHE_TAG_MSB-`ICACHE_TAG_LSB:0] line_tag_t;

   // address bits 31..3 split into fields
   typedef struct packed {
      line_tag_t                                    tag;
      logic [`ICACHE_INDEX_MSB-`ICACHE_INDEX_LSB:0] index;
      beat_t                                        word;
   } fetch_addr_fields_s;

   // raw word for capture and biu, fields for arrays
   typedef union packed {
      logic [28:0]        raw;
      fetch_addr_fields_s f;
   } fetch_addr_u;

endpackage

// File: icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// byte address split, tag bits
`define ICACHE_TAG_MSB 31
`define ICACHE_TAG_LSB 15

// set index bits
`define ICACHE_INDEX_MSB 14
`define ICACHE_INDEX_LSB 5

// 64-bit beats per 32-byte line
`define ICACHE_LINE_BEATS 4

// sets per way
`define ICACHE_SETS 1024

`endif
